// ==== Makefile ====
# Verilator build and run for the RS(200,168) encoder testbench

VERILATOR ?= verilator
TOP       ?= tb_rs_encoder
FLIST     ?= rs_encoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Pass or fail comes from the log, not from the simulator exit code
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/rs_pkg.sv ====
// Shared constants and GF(2^8) arithmetic for the RS(200,168) encoder
package rs_pkg;

    // Symbol and code geometry
    localparam int sym_w  = 8;                      // Bits per symbol
    localparam int code_n = 200;                    // Codeword length in symbols
    localparam int code_k = 168;                    // Information symbols per frame
    localparam int par_n  = code_n - code_k;        // Parity symbols per frame
    localparam int cnt_w  = $clog2(code_n + 1);     // Symbol counter width

    // Primitive polynomial x^8 + x^4 + x^3 + x^2 + 1
    localparam logic [sym_w:0] gf_poly = 9'h11D;

    // Shift-and-add multiply in GF(2^8)
    function automatic logic [sym_w-1:0] gf_mul(
        input logic [sym_w-1:0] a,
        input logic [sym_w-1:0] b
    );
        logic [sym_w-1:0] prod;
        logic [sym_w-1:0] mcand;
        prod  = '0;
        mcand = a;
        for (int i = 0; i < sym_w; i++) begin
            if (b[i]) begin
                prod = prod ^ mcand;                // Add current multiple of a
            end
            // Multiply by alpha, reduce when bit 7 falls off
            if (mcand[sym_w-1]) begin
                mcand = (mcand << 1) ^ gf_poly[sym_w-1:0];
            end else begin
                mcand = mcand << 1;
            end
        end
        return prod;
    endfunction

    // Generator g(x) = (x + a^0)(x + a^1)...(x + a^31)
    // Built up one root at a time, monic top term dropped on return
    function automatic logic [par_n-1:0][sym_w-1:0] gen_poly_calc();
        logic [par_n:0][sym_w-1:0] g;
        logic [sym_w-1:0]          root;
        g    = '0;
        g[0] = sym_w'(1);                           // Start from g(x) = 1
        root = sym_w'(1);                           // alpha^0
        for (int i = 0; i < par_n; i++) begin
            // Multiply by (x + root), high terms first so g[j-1] is still old
            for (int j = par_n; j > 0; j--) begin
                g[j] = g[j-1] ^ gf_mul(g[j], root);
            end
            g[0] = gf_mul(g[0], root);
            root = gf_mul(root, sym_w'(2));         // Step to next power of alpha
        end
        return g[par_n-1:0];
    endfunction

    // Generator coefficients g0..g31, lowest degree first
    // g32 is 1 and never stored
    localparam logic [par_n-1:0][sym_w-1:0] gen_coef = gen_poly_calc();

endpackage

// ==== dv/rs_encoder_golden.txt ====
// Odd lines: 168 information symbols in hex, first transmitted symbol first
// Even lines: expected syndromes S0..S31 of the emitted codeword in hex
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f 40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e 7f 80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f 90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e 9f a0 a1 a2 a3 a4 a5 a6 a7
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a ff 00 a5 5a
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
3c 91 07 e4 5b c8 2a 7f d0 16 b3 48 ee 05 9a 61 24 f7 8c 3e a1 52 c9 0b 76 e8 13 bd 40 9f 2c d5 68 01 fa 37 84 cb 5e 12 a9 70 26 db 8f 43 b1 0e 95 ec 39 62 d7 1a 88 f4 4d b6 03 7a c1 2f 90 e5 58 1c a3 6f 34 d9 87 fe 0a 63 bc 45 f1 2d 9e 71 c6 18 e3 5d 8a 27 b0 4e 93 fc 06 69 d2 3b a7 10 e1 54 8d 2b 7e c3 19 a6 35 f9 42 bf 0c 86 d3 67 ab 21 ce 74 09 e0 5f 98 3a c4 11 8b f6 4f 2e b9 d6 73 05 ea 60 9c 17 c2 4b a0 fd 36 81 58 e7 0d b4 29 6c 93 de 47 a8 1f 72 c5 3d e9 50 8e 14 bb 66 f3 0f a2 cd 31 79 e6
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

// ==== dv/tb_rs_encoder.sv ====
`timescale 1ns/1ps

// Testbench for the serial RS(200,168) encoder
// Each codeword is checked for the systematic property and for zero syndromes
module tb_rs_encoder;
    import rs_pkg::*;

    localparam int frame_syms  = code_k + par_n;    // Symbols per codeword
    localparam int max_frames  = 8;
    localparam int accept_wait = 1000;              // Cycles a bit may wait for ready
    localparam int output_wait = 1000;              // Cycles between two output bits
    localparam int idle_cycles = 100;               // Quiet time after the last frame
    localparam logic [8:0] prim_poly = 9'h11D;      // x^8 + x^4 + x^3 + x^2 + 1

    logic clk;
    logic rstn;
    logic data_in;
    logic data_in_valid;
    logic ready;
    logic data_out;
    logic data_out_valid;

    logic [sym_w-1:0] info_mem [max_frames][code_k];    // Stimulus from golden file
    logic [sym_w-1:0] synd_mem [max_frames][par_n];     // Expected syndromes
    logic [sym_w-1:0] out_syms [frame_syms];            // Last collected codeword
    logic [7:0]       exp_tab  [255];                   // alpha^i
    int               log_tab  [256];
    int               n_frames;
    integer           seed;

    rs_encoder_top UUT (
        .clk            (clk),
        .rstn           (rstn),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .ready          (ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // 40 ns period
    end

    // Reports what went wrong and ends the run
    task automatic fail_now(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_now("Value mismatch");
        end
    endtask

    // Log and antilog tables built by stepping alpha
    task automatic build_tables();
        logic [8:0] v;
        v = 9'd1;
        for (int i = 0; i < 255; i++) begin
            exp_tab[i]    = v[7:0];
            log_tab[v[7:0]] = i;
            v = v << 1;
            if (v[8]) v = v ^ prim_poly;            // Reduce by the field polynomial
        end
    endtask

    function automatic logic [7:0] gf_product(input logic [7:0] a, input logic [7:0] b);
        if (a == 8'd0 || b == 8'd0) return 8'd0;
        return exp_tab[(log_tab[a] + log_tab[b]) % 255];
    endfunction

    task automatic load_golden();
        integer       fd;
        integer       rc;
        logic [31:0]  val;
        logic [1023:0] line_buf;
        fd = $fopen("dv/rs_encoder_golden.txt", "r");
        if (fd == 0) fail_now("Golden file dv/rs_encoder_golden.txt could not be opened");
        rc = $fgets(line_buf, fd);                  // Two column description lines
        rc = $fgets(line_buf, fd);
        n_frames = 0;
        while (n_frames < max_frames) begin
            rc = $fscanf(fd, " %h", val);
            if (rc != 1) break;                     // End of file between frames
            info_mem[n_frames][0] = val[7:0];
            for (int s = 1; s < code_k; s++) begin
                rc = $fscanf(fd, " %h", val);
                if (rc != 1) fail_now("Golden file ends inside an information line");
                info_mem[n_frames][s] = val[7:0];
            end
            for (int i = 0; i < par_n; i++) begin
                rc = $fscanf(fd, " %h", val);
                if (rc != 1) fail_now("Golden file ends inside a syndrome line");
                synd_mem[n_frames][i] = val[7:0];
            end
            n_frames++;
        end
        $fclose(fd);
        if (n_frames < 2) fail_now("Golden file holds fewer than two frames");
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_bit(input logic b);
        int waited;
        waited        = 0;
        data_in       = b;
        data_in_valid = 1'b1;
        while (!ready) begin                        // Stalled by parity drain
            waited++;
            if (waited > accept_wait) fail_now("Input ready stayed low too long");
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic send_frame(input int f, input int n_bits, input bit gaps);
        int sent;
        int gap;
        sent = 0;
        for (int s = 0; s < code_k; s++) begin
            for (int b = sym_w - 1; b >= 0; b--) begin
                if (sent < n_bits) begin
                    if (gaps && (($random(seed) & 7) == 0)) begin
                        gap           = ($random(seed) & 3) + 1;
                        data_in_valid = 1'b0;
                        repeat (gap) @(negedge clk);
                    end
                    send_bit(info_mem[f][s][b]);    // MSB first
                    sent++;
                end
            end
        end
        data_in_valid = 1'b0;
    endtask

    task automatic take_bit(output logic b);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!data_out_valid) begin
            waited++;
            if (waited > output_wait) fail_now("No output bit arrived in time");
            @(negedge clk);
        end
        b = data_out;
    endtask

    task automatic collect_frame();
        logic b;
        for (int s = 0; s < frame_syms; s++) begin
            for (int k = sym_w - 1; k >= 0; k--) begin
                take_bit(b);
                out_syms[s][k] = b;
            end
        end
    endtask

    task automatic verify_frame(input int f);
        logic [7:0] syn;
        bit         all_zero;
        all_zero = 1'b1;
        for (int s = 0; s < code_k; s++) begin   // Systematic part
            check_val($sformatf("frame %0d info symbol %0d", f, s),
                      out_syms[s], info_mem[f][s]);
            if (info_mem[f][s] != '0) all_zero = 1'b0;
        end
        // Horner evaluation at alpha^i, first symbol is the highest degree
        for (int i = 0; i < par_n; i++) begin
            syn = 8'd0;
            for (int j = 0; j < frame_syms; j++) begin
                syn = gf_product(syn, exp_tab[i]) ^ out_syms[j];
            end
            check_val($sformatf("frame %0d syndrome S%0d", f, i), syn, synd_mem[f][i]);
        end
        if (all_zero) begin                         // Linear code, zero in gives zero parity
            for (int s = code_k; s < frame_syms; s++) begin
                check_val($sformatf("frame %0d parity symbol %0d", f, s),
                          out_syms[s], 8'd0);
            end
        end
    endtask

    task automatic monitor_frames(input int first, input int last);
        for (int f = first; f <= last; f++) begin
            collect_frame();
            verify_frame(f);
        end
    endtask

    task automatic drive_frames(input int first, input int last);
        for (int f = first; f <= last; f++) begin
            send_frame(f, code_k * sym_w, f > 0); // Gaps from frame 1 on
        end
    endtask

    initial begin
        data_in       = 1'b0;
        data_in_valid = 1'b0;
        rstn          = 1'b0;
        seed          = 32'h85dd_b6be;
        build_tables();
        load_golden();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_val("data_out_valid after reset", data_out_valid, 1'b0);
        check_val("ready after reset", ready, 1'b1);

        // All frames back to back, driver and monitor side by side
        fork
            drive_frames(0, n_frames - 1);
            monitor_frames(0, n_frames - 1);
        join

        // Exactly one codeword per frame, nothing trailing
        repeat (idle_cycles) begin
            @(negedge clk);
            check_val("data_out_valid after last frame", data_out_valid, 1'b0);
        end

        // Abort a frame halfway through, then encode a clean one
        send_frame(n_frames - 1, code_k * sym_w / 2, 1'b0);
        rstn = 1'b0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        check_val("ready after mid-frame reset", ready, 1'b1);
        check_val("data_out_valid after mid-frame reset", data_out_valid, 1'b0);
        fork
            send_frame(1, code_k * sym_w, 1'b1);
            monitor_frames(1, 1);
        join

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== rs_enc/rs_parity_lfsr.sv ====
`timescale 1ns/1ps

// Symbol-serial systematic RS(200,168) encoder
// Passes 168 information symbols, then drains 32 parity symbols
module rs_parity_lfsr (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [rs_pkg::sym_w-1:0] info_sym,
    input  logic                     info_valid,
    output logic                     info_ready,
    output logic [rs_pkg::sym_w-1:0] cw_sym,
    output logic                     cw_valid,
    input  logic                     cw_ready
);
    import rs_pkg::*;

    logic [par_n-1:0][sym_w-1:0] par_q;             // Parity remainder, par_q[31] is top
    logic [par_n-1:0][sym_w-1:0] par_next;          // Remainder after one info symbol
    logic [cnt_w-1:0]            cnt_q;             // Symbols emitted in this frame
    logic [sym_w-1:0]            fb;                // LFSR feedback symbol
    logic                        pass_phase;
    logic                        drain_phase;
    logic                        out_free;
    logic                        info_fire;
    logic                        par_fire;
    logic                        last_sym;

    // Phase from the symbol counter
    assign pass_phase  = (cnt_q < cnt_w'(code_k));
    assign drain_phase = !pass_phase;
    assign last_sym    = (cnt_q == cnt_w'(code_n - 1));

    // Output register can take a new symbol if empty or being read
    assign out_free   = !cw_valid || cw_ready;
    assign info_ready = pass_phase && out_free;     // Low for the whole parity drain
    assign info_fire  = info_valid && info_ready;
    assign par_fire   = drain_phase && out_free;

    assign fb = info_sym ^ par_q[par_n-1];

    // One division step of the info polynomial by g(x)
    always_comb begin
        par_next[0] = gf_mul(fb, gen_coef[0]);
        for (int j = 1; j < par_n; j++) begin
            par_next[j] = par_q[j-1] ^ gf_mul(fb, gen_coef[j]);
        end
    end

    // Remainder, counter and output valid
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            par_q    <= '0;
            cnt_q    <= '0;
            cw_valid <= 1'b0;
        end else begin
            if (info_fire) begin
                par_q <= par_next;                  // Absorb info symbol
            end else if (par_fire) begin
                if (last_sym) begin
                    par_q <= '0;                    // Fresh remainder for next frame
                end else begin
                    par_q <= {par_q[par_n-2:0], sym_w'(0)};  // Shift toward top
                end
            end

            if (info_fire || par_fire) begin
                cnt_q    <= last_sym ? '0 : cnt_q + cnt_w'(1);
                cw_valid <= 1'b1;
            end else if (cw_ready) begin
                cw_valid <= 1'b0;                   // Consumed, nothing new
            end
        end
    end

    // Registered codeword symbol
    // Info passes straight through, parity comes off the top stage
    always_ff @(posedge clk) begin
        if (info_fire) begin
            cw_sym <= info_sym;
        end else if (par_fire) begin
            cw_sym <= par_q[par_n-1];
        end
    end

    // Counter wraps at the end of the codeword
    a_cnt_range: assert property (
        @(posedge clk) disable iff (!rstn)
        cnt_q < cnt_w'(code_n)
    );

    // No information symbol slips in while parity drains
    a_drain_blocks_info: assert property (
        @(posedge clk) disable iff (!rstn)
        drain_phase |-> !info_ready
    );

endmodule

// ==== rs_encoder.f ====
common/rs_pkg.sv
rtl/symbol_deserializer.sv
rs_enc/rs_parity_lfsr.sv
rtl/symbol_serializer.sv
rtl/rs_encoder_top.sv
dv/tb_rs_encoder.sv

// ==== rtl/rs_encoder_top.sv ====
`timescale 1ns/1ps

// Serial in, serial out RS(200,168) encoder
module rs_encoder_top (
    input  logic clk,
    input  logic rstn,
    input  logic data_in,
    input  logic data_in_valid,
    output logic ready,
    output logic data_out,
    output logic data_out_valid
);
    import rs_pkg::*;

    logic [sym_w-1:0] info_sym;                     // Deserializer to encoder
    logic             info_valid;
    logic             info_ready;
    logic [sym_w-1:0] cw_sym;                       // Encoder to serializer
    logic             cw_valid;
    logic             cw_ready;

    symbol_deserializer u_deser (
        .clk           (clk),
        .rstn          (rstn),
        .data_in       (data_in),
        .data_in_valid (data_in_valid),
        .ready         (ready),
        .info_sym      (info_sym),
        .info_valid    (info_valid),
        .info_ready    (info_ready)
    );

    rs_parity_lfsr u_lfsr (
        .clk        (clk),
        .rstn       (rstn),
        .info_sym   (info_sym),
        .info_valid (info_valid),
        .info_ready (info_ready),
        .cw_sym     (cw_sym),
        .cw_valid   (cw_valid),
        .cw_ready   (cw_ready)
    );

    symbol_serializer u_ser (
        .clk            (clk),
        .rstn           (rstn),
        .cw_sym         (cw_sym),
        .cw_valid       (cw_valid),
        .cw_ready       (cw_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

endmodule

// ==== rtl/symbol_deserializer.sv ====
`timescale 1ns/1ps

// Serial bit stream to 8-bit symbols, MSB first
module symbol_deserializer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     data_in,
    input  logic                     data_in_valid,
    output logic                     ready,
    output logic [rs_pkg::sym_w-1:0] info_sym,
    output logic                     info_valid,
    input  logic                     info_ready
);
    import rs_pkg::*;

    logic [$clog2(sym_w)-1:0] bit_cnt;              // Bits collected in current symbol
    logic [sym_w-1:0]         shift_q;              // Assembly register, doubles as output
    logic                     bit_fire;
    logic                     sym_done;

    // Stall the serial input only while a full symbol is stuck downstream
    assign ready    = !(info_valid && !info_ready);
    assign bit_fire = data_in_valid && ready;
    assign sym_done = bit_fire && (int'(bit_cnt) == sym_w - 1);
    assign info_sym = shift_q;

    // Control state
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bit_cnt    <= '0;
            info_valid <= 1'b0;
        end else begin
            if (bit_fire) begin
                bit_cnt <= sym_done ? '0 : bit_cnt + 1'b1;  // Wraps after 8th bit
            end
            if (sym_done) begin
                info_valid <= 1'b1;                 // Symbol ready next cycle
            end else if (info_ready) begin
                info_valid <= 1'b0;                 // Handed off downstream
            end
        end
    end

    // Payload shift, oldest bit ends up in the MSB
    always_ff @(posedge clk) begin
        if (bit_fire) begin
            shift_q <= {shift_q[sym_w-2:0], data_in};
        end
    end

    // Held symbol must not move while waiting for the encoder
    a_sym_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        (info_valid && !info_ready) |=> $stable(info_sym)
    );

endmodule

// ==== rtl/symbol_serializer.sv ====
`timescale 1ns/1ps

// Codeword symbols out as a serial stream, MSB first
module symbol_serializer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [rs_pkg::sym_w-1:0] cw_sym,
    input  logic                     cw_valid,
    output logic                     cw_ready,
    output logic                     data_out,
    output logic                     data_out_valid
);
    import rs_pkg::*;

    logic [sym_w-1:0]         shift_q;              // Bits still to send, MSB next
    logic [$clog2(sym_w)-1:0] bit_cnt;              // Position within current symbol
    logic                     last_bit;
    logic                     load;

    assign last_bit = data_out_valid && (int'(bit_cnt) == sym_w - 1);

    // Reload while idle or on the final bit, so symbols run back to back
    assign cw_ready = !data_out_valid || last_bit;
    assign load     = cw_valid && cw_ready;

    assign data_out = shift_q[sym_w-1];

    // Control state
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bit_cnt        <= '0;
            data_out_valid <= 1'b0;
        end else begin
            if (load) begin
                bit_cnt        <= '0;
                data_out_valid <= 1'b1;
            end else if (data_out_valid) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (last_bit) begin
                    data_out_valid <= 1'b0;         // Ran dry
                end
            end
        end
    end

    // Payload shift
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= cw_sym;
        end else if (data_out_valid) begin
            shift_q <= {shift_q[sym_w-2:0], 1'b0};
        end
    end

    // A symbol, once started, goes out without gaps
    a_no_mid_gap: assert property (
        @(posedge clk) disable iff (!rstn)
        (data_out_valid && !last_bit) |=> data_out_valid
    );

endmodule
